/* filelist.f */
hdl/spi_cfg_pkg.sv
hdl/spi_frame_pkg.sv
hdl/spi_word_if.sv
hdl/spi_tx_buffer.sv
hdl/spi_shift_engine.sv
hdl/spi_rx_buffer.sv
hdl/spi_master.sv
verification/spi_master_tb.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  - hdl/spi_cfg_pkg.sv
  - hdl/spi_frame_pkg.sv
  - hdl/spi_word_if.sv
  - hdl/spi_tx_buffer.sv
  - hdl/spi_shift_engine.sv
  - hdl/spi_rx_buffer.sv
  - hdl/spi_master.sv
  - target: test
    files:
      - verification/spi_master_tb.sv

/* verification/spi_master_tb.sv */
// Testbench for the SPI master with loopback device model, directed tests, compare tasks and summary.
`timescale 1ns/1ns
`default_nettype none

module spi_master_tb;

    localparam int max_cycles = 40000;           // All frames of all tests fit many times over.

    logic                   clk;
    logic                   rst;
    spi_cfg_pkg::spi_mode_t mode;
    logic                   lsbfirst;
    spi_cfg_pkg::presc_t    prescaler;
    logic                   wr;
    logic                   rd;
    logic                   rst_tx_error;
    spi_cfg_pkg::word_t     tx_data;
    logic                   tx_completed;
    logic                   rx_completed;
    logic                   tx_error;
    spi_cfg_pkg::word_t     rx_data;
    logic                   sck;
    logic                   mosi;
    logic                   ss;

    int value_errors = 0;                        // Wrong values seen by the compare tasks.
    int event_errors = 0;                        // Events that never came.
    int cycle_count  = 0;
    int ss_rises     = 0;                        // Rising edges of ss seen by the model.

    spi_cfg_pkg::word_t captured[$];             // Words that the device model collected.
    spi_cfg_pkg::word_t shift_in;
    int                 bits_in = 0;
    logic               prev_sck;
    logic               prev_mosi;
    logic               prev_ss;
    logic               leading;

    // The slave simply echoes mosi, so every received word equals the sent one.
    spi_master spi_master_i (
        .clk (clk), .rst (rst), .mode (mode), .lsbfirst (lsbfirst), .prescaler (prescaler),
        .wr (wr), .rd (rd), .rst_tx_error (rst_tx_error), .tx_data (tx_data),
        .tx_completed (tx_completed), .rx_completed (rx_completed), .tx_error (tx_error),
        .rx_data (rx_data), .sck (sck), .mosi (mosi), .miso (mosi), .ss (ss)
    );

    always #2 clk = ~clk;                        // 4 ns period.

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Run stopped after %0d cycles, the tests did not finish.", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Device model. Pins are looked at on the falling clock edge, where they are stable.

    always @(negedge clk) begin
        if (!rst && prev_ss === 1'b0 && sck !== prev_sck) begin
            leading = (sck != mode.cpol);        // Leading edge leaves the idle level.
            if (leading != mode.cpha) begin
                // The bit in effect just before the sampling edge is the one taken.
                if (lsbfirst) shift_in = {prev_mosi, shift_in[spi_cfg_pkg::word_len-1:1]};
                else          shift_in = {shift_in[spi_cfg_pkg::word_len-2:0], prev_mosi};
                bits_in++;
                if (bits_in == spi_cfg_pkg::word_len) begin
                    captured.push_back(shift_in);
                    bits_in = 0;
                end
            end
        end
        if (prev_ss === 1'b0 && ss === 1'b1) ss_rises++;
        prev_sck  = sck;
        prev_mosi = mosi;
        prev_ss   = ss;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and helpers.

    task automatic compare_word(input string name, input spi_cfg_pkg::word_t exp,
                                input spi_cfg_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    // Frame length of 2*word_len half-periods, each 2^(p+1) cycles, plus some slack.
    function automatic int frame_limit(input int p);
        return (2 << p) * 2 * spi_cfg_pkg::word_len + 8;
    endfunction

    task automatic check_captured(input string name, input spi_cfg_pkg::word_t exp);
        if (captured.size() == 0) begin
            $display("%s: the device model did not collect a word.", name);
            event_errors++;
        end else begin
            compare_word(name, exp, captured.pop_front());
        end
    endtask

    task automatic wait_rx(input string name, input int limit);
        int n = 0;
        while (!rx_completed && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!rx_completed) begin
            $display("%s: rx_completed did not rise within %0d cycles.", name, limit);
            event_errors++;
        end
    endtask

    task automatic set_frame(input int mode_num, input logic lsb, input int p);
        mode.cpol = mode_num[1];                 // Mode number is {cpol, cpha}.
        mode.cpha = mode_num[0];
        lsbfirst  = lsb;
        prescaler = spi_cfg_pkg::presc_t'(p);
    endtask

    task automatic pulse_wr(input spi_cfg_pkg::word_t w);
        tx_data = w;
        wr      = 1'b1;
        @(negedge clk);
        wr      = 1'b0;
    endtask

    task automatic pulse_rd();
        rd = 1'b1;
        @(negedge clk);
        rd = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests.

    task automatic reset_levels(input logic cpol);
        string name = $sformatf("reset cpol=%0b", cpol);
        mode.cpol = cpol;
        mode.cpha = 1'b0;
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_bit(name, 1'b1, ss);
        compare_bit(name, 1'b1, mosi);
        compare_bit(name, cpol, sck);
        compare_bit(name, 1'b1, tx_completed);
        compare_bit(name, 1'b0, rx_completed);
        compare_bit(name, 1'b0, tx_error);
    endtask

    task automatic transfer(input string name, input int mode_num, input logic lsb, input int p);
        spi_cfg_pkg::word_t w = spi_cfg_pkg::word_t'($urandom);
        set_frame(mode_num, lsb, p);
        pulse_wr(w);
        wait_rx(name, frame_limit(p));
        compare_word(name, w, rx_data);
        check_captured(name, w);
        pulse_rd();
        compare_bit(name, 1'b0, rx_completed);   // Cleared by the read.
    endtask

    task automatic write_error();
        spi_cfg_pkg::word_t w0 = spi_cfg_pkg::word_t'($urandom);
        spi_cfg_pkg::word_t w1 = spi_cfg_pkg::word_t'($urandom);
        spi_cfg_pkg::word_t w2 = ~w1;            // Differs in every bit from the buffered word.
        set_frame(0, 1'b0, 0);
        pulse_wr(w0);
        while (!tx_completed) @(negedge clk);    // Engine is busy with the first word.
        pulse_wr(w1);                            // Waits in the buffer behind the running frame.
        compare_bit("write error", 1'b0, tx_completed);
        pulse_wr(w2);                            // Second write hits the full buffer.
        compare_bit("write error", 1'b1, tx_error);
        wait_rx("write error", frame_limit(0));
        compare_word("write error", w0, rx_data);
        check_captured("write error", w0);
        pulse_rd();
        wait_rx("write error", frame_limit(0));
        compare_word("write error", w1, rx_data);
        check_captured("write error", w1);
        pulse_rd();
        compare_bit("write error", 1'b1, tx_error); // Sticky until cleared.
        rst_tx_error = 1'b1;
        @(negedge clk);
        rst_tx_error = 1'b0;
        compare_bit("write error", 1'b0, tx_error);
    endtask

    task automatic back_to_back();
        spi_cfg_pkg::word_t w1 = spi_cfg_pkg::word_t'($urandom);
        spi_cfg_pkg::word_t w2 = spi_cfg_pkg::word_t'($urandom);
        int rises_before = ss_rises;
        set_frame(0, 1'b0, 0);
        pulse_wr(w1);
        while (!tx_completed) @(negedge clk);    // Engine has taken the first word.
        compare_bit("back to back", 1'b0, ss);
        pulse_wr(w2);
        wait_rx("back to back", frame_limit(0));
        compare_count("back to back ss rises", 0, ss_rises - rises_before);
        compare_word("back to back", w1, rx_data);
        check_captured("back to back", w1);
        pulse_rd();                              // Read while the second frame runs.
        wait_rx("back to back", frame_limit(0));
        compare_word("back to back", w2, rx_data);
        check_captured("back to back", w2);
        pulse_rd();
        compare_count("back to back ss rises", 1, ss_rises - rises_before);
    endtask

    task automatic divider(input int p);
        string              name = $sformatf("divider p=%0d", p);
        spi_cfg_pkg::word_t w    = spi_cfg_pkg::word_t'($urandom);
        logic               last;
        int                 gap;
        set_frame(0, 1'b0, p);
        pulse_wr(w);
        while (ss) @(negedge clk);
        last = sck;
        while (sck == last) @(negedge clk);      // First edge of the frame.
        repeat (2 * spi_cfg_pkg::word_len - 1) begin
            last = sck;
            gap  = 0;
            while (sck == last) begin
                @(negedge clk);
                gap++;
            end
            compare_count(name, 2 << p, gap);    // Half-period of 2^(p+1) cycles.
        end
        wait_rx(name, frame_limit(p));
        compare_word(name, w, rx_data);
        check_captured(name, w);
        pulse_rd();
    endtask

    initial begin
        int seed_ret;
        clk          = 1'b0;
        rst          = 1'b1;
        mode         = '0;
        lsbfirst     = 1'b0;
        prescaler    = '0;
        wr           = 1'b0;
        rd           = 1'b0;
        rst_tx_error = 1'b0;
        tx_data      = '0;
        seed_ret     = $urandom(32'h194b);
        reset_levels(1'b0);
        reset_levels(1'b1);
        for (int m = 0; m < 4; m++) transfer($sformatf("mode %0d msb first", m), m, 1'b0, 0);
        transfer("mode 0 lsb first", 0, 1'b1, 0);
        transfer("mode 3 lsb first", 3, 1'b1, 0);
        write_error();
        back_to_back();
        divider(0);
        divider(2);
        divider(3);
        if (captured.size() != 0) begin
            $display("The device model collected %0d words that no test expected.",
                     captured.size());
            event_errors++;
        end
        $display("Errors: %0d wrong values, %0d missing or extra events.",
                 value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/spi_master.sv */
// SPI master top level joining transmit buffer, shift engine and receive buffer.
`timescale 1ns/1ns
`default_nettype none

module spi_master (
    input  logic                   clk,
    input  logic                   rst,

    // Frame settings, sampled when a frame starts.
    input  spi_cfg_pkg::spi_mode_t mode,
    input  logic                   lsbfirst,
    input  spi_cfg_pkg::presc_t    prescaler,

    // Host side strobes and data.
    input  logic                   wr,
    input  logic                   rd,
    input  logic                   rst_tx_error,
    input  spi_cfg_pkg::word_t     tx_data,
    output logic                   tx_completed,
    output logic                   rx_completed,
    output logic                   tx_error,
    output spi_cfg_pkg::word_t     rx_data,

    // SPI pins.
    output logic                   sck,
    output logic                   mosi,
    input  logic                   miso,
    output logic                   ss
);

    spi_word_if words ();                        // Shared by all three parts.

    //////////////////////////////////////////////////////////////////////
    // Input side.

    spi_tx_buffer spi_tx_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr),
        .tx_data      (tx_data),
        .rst_tx_error (rst_tx_error),
        .tx_completed (tx_completed),
        .tx_error     (tx_error),
        .words        (words.tx_side)
    );

    //////////////////////////////////////////////////////////////////////
    // Processing.

    spi_shift_engine spi_shift_engine_i (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .lsbfirst  (lsbfirst),
        .prescaler (prescaler),
        .miso      (miso),
        .sck       (sck),
        .mosi      (mosi),
        .ss        (ss),
        .words     (words.engine)
    );

    //////////////////////////////////////////////////////////////////////
    // Output side.

    spi_rx_buffer spi_rx_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .rd           (rd),
        .rx_data      (rx_data),
        .rx_completed (rx_completed),
        .words        (words.rx_side)
    );

endmodule

`default_nettype wire

/* hdl/spi_rx_buffer.sv */
// Receive buffer holding the last word and its completion flag.
`timescale 1ns/1ns
`default_nettype none

module spi_rx_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd,               // Acknowledges the held word.
    output spi_cfg_pkg::word_t rx_data,          // Last received word, always visible.
    output logic               rx_completed,     // High from a finished frame until rd.
    spi_word_if.rx_side        words
);

    //////////////////////////////////////////////////////////////////////
    // Completion flag.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_completed <= 1'b0;
        end else if (words.rx_done) begin
            rx_completed <= 1'b1;                // A fresh word beats a same-cycle read.
        end else if (rd) begin
            rx_completed <= 1'b0;
        end
    end

    // An unread word is overwritten, and rd leaves the word in place.
    always_ff @(posedge clk) begin
        if (words.rx_done) begin
            rx_data <= words.rx_word;
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_shift_engine.sv */
// SPI shift engine with clock divider, edge counter, shift registers and pin drivers.
`timescale 1ns/1ns
`default_nettype none

module spi_shift_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  spi_cfg_pkg::spi_mode_t mode,
    input  logic                   lsbfirst,     // 1 shifts the least significant bit first.
    input  spi_cfg_pkg::presc_t    prescaler,
    input  logic                   miso,
    output logic                   sck,
    output logic                   mosi,
    output logic                   ss,           // Active low select.
    spi_word_if.engine             words
);

    spi_frame_pkg::engine_state_t state;
    spi_frame_pkg::edge_count_u   edge_cnt;      // Half-periods done in this frame.
    spi_cfg_pkg::presc_cnt_t      presc_cnt;     // Cycles spent in the current half-period.
    spi_cfg_pkg::presc_cnt_t      half_limit;    // Last count of a half-period.

    spi_cfg_pkg::spi_mode_t mode_l;              // Settings frozen for the running frame.
    logic                   lsb_l;
    spi_cfg_pkg::presc_t    presc_l;

    spi_cfg_pkg::word_t tx_shift;                // Bits still to be sent.
    spi_cfg_pkg::word_t rx_shift;                // Bits gathered from miso.

    logic started;                               // Set once the first frame has begun.
    logic mosi_q;                                // Data bit presented while ss is low.
    logic tx_out;                                // Next bit in the latched order.
    logic first_bit;                             // Opening bit of the buffered word.
    logic start;
    logic half_end;
    logic sample_edge;
    logic frame_end;

    //////////////////////////////////////////////////////////////////////
    // Decoding.

    // All ones shifted down leaves 2^(p+1)-1, so a half-period spans 2^(p+1) cycles.
    assign half_limit = {spi_cfg_pkg::presc_cnt_len{1'b1}}
                        >> (spi_cfg_pkg::presc_t'(spi_cfg_pkg::presc_cnt_len - 1) - presc_l);

    assign start       = (state == spi_frame_pkg::st_idle) && words.tx_pending;
    assign half_end    = (state == spi_frame_pkg::st_busy) && (presc_cnt == half_limit);
    assign sample_edge = half_end && (edge_cnt.part.phase == mode_l.cpha); // Sample and shift.
    // The second half of the last bit closes the frame.
    assign frame_end   = (edge_cnt.part.bit_num == spi_frame_pkg::last_bit_num)
                         && edge_cnt.part.phase;

    assign tx_out    = lsb_l ? tx_shift[0] : tx_shift[spi_cfg_pkg::word_len-1];
    assign first_bit = lsbfirst ? words.tx_word[0] : words.tx_word[spi_cfg_pkg::word_len-1];

    //////////////////////////////////////////////////////////////////////
    // Control state.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= spi_frame_pkg::st_idle;
            edge_cnt.raw   <= '0;
            presc_cnt      <= '0;
            ss             <= 1'b1;
            mosi_q         <= 1'b1;
            started        <= 1'b0;
            words.tx_taken <= 1'b0;
            words.rx_done  <= 1'b0;
        end else begin
            words.tx_taken <= 1'b0;              // Both events are single pulses.
            words.rx_done  <= 1'b0;
            if (start) begin
                state          <= spi_frame_pkg::st_busy;
                words.tx_taken <= 1'b1;          // Frees the buffer for the next word.
                ss             <= 1'b0;
                started        <= 1'b1;
                presc_cnt      <= '0;
                // With cpha 0 the first bit must be valid before the leading edge.
                mosi_q <= mode.cpha ? 1'b1 : first_bit;
            end else if (half_end) begin
                presc_cnt    <= '0;
                edge_cnt.raw <= edge_cnt.raw + 1'b1; // One sck edge per half-period.
                if (frame_end) begin
                    edge_cnt.raw  <= '0;         // Brings sck back to idle.
                    state         <= spi_frame_pkg::st_idle;
                    words.rx_done <= 1'b1;
                    // A waiting word keeps the slave selected for the next frame.
                    if (!words.tx_pending) begin
                        ss <= 1'b1;
                    end
                end else if (edge_cnt.part.phase != mode_l.cpha) begin
                    mosi_q <= tx_out;            // Launch edge.
                end
            end else if (state == spi_frame_pkg::st_busy) begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame settings and shift registers.

    always_ff @(posedge clk) begin
        if (start) begin
            mode_l   <= mode;
            lsb_l    <= lsbfirst;
            presc_l  <= prescaler;
            tx_shift <= words.tx_word;
        end else if (sample_edge) begin
            // Ones fill in behind the outgoing bits.
            if (lsb_l) begin
                tx_shift <= {1'b1, tx_shift[spi_cfg_pkg::word_len-1:1]};
                rx_shift <= {miso, rx_shift[spi_cfg_pkg::word_len-1:1]};
            end else begin
                tx_shift <= {tx_shift[spi_cfg_pkg::word_len-2:0], 1'b1};
                rx_shift <= {rx_shift[spi_cfg_pkg::word_len-2:0], miso};
            end
        end
    end

    assign words.rx_word = rx_shift;             // Stable while rx_done is high.

    // The phase bit toggles sck, cpol flips it. Before any frame the live cpol rules.
    assign sck  = started ? (edge_cnt.part.phase ^ mode_l.cpol) : mode.cpol;
    assign mosi = ss ? 1'b1 : mosi_q;            // Line rests high when deselected.

    ss_low_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        (state == spi_frame_pkg::st_busy) |-> !ss
    );

    rx_done_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        words.rx_done |=> !words.rx_done
    );

endmodule

`default_nettype wire

/* hdl/spi_tx_buffer.sv */
// Transmit buffer with its occupied flag and sticky write error.
`timescale 1ns/1ns
`default_nettype none

module spi_tx_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr,               // Write strobe for tx_data.
    input  spi_cfg_pkg::word_t tx_data,
    input  logic               rst_tx_error,     // Clears tx_error, wins over a same-cycle wr.
    output logic               tx_completed,     // High while the buffer is free.
    output logic               tx_error,         // Sticky, set by a write to a full buffer.
    spi_word_if.tx_side        words
);

    logic accept;                                // Write lands in an empty buffer.
    logic reject;                                // Write hits a full buffer.

    assign accept = wr && !words.tx_pending;
    assign reject = wr && words.tx_pending;

    assign tx_completed = !words.tx_pending;     // Free exactly when nothing is pending.

    //////////////////////////////////////////////////////////////////////
    // Occupied flag and error flag.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            words.tx_pending <= 1'b0;
            tx_error         <= 1'b0;
        end else begin
            // A write and a take never meet, since one needs the flag low and
            // the other needs it high.
            if (accept) begin
                words.tx_pending <= 1'b1;
            end else if (words.tx_taken) begin
                words.tx_pending <= 1'b0;        // Engine has its own copy now.
            end

            if (rst_tx_error) begin
                tx_error <= 1'b0;
            end else if (reject) begin
                tx_error <= 1'b1;                // The rejected word is simply dropped.
            end
        end
    end

    // The held word only changes on an accepted write.
    always_ff @(posedge clk) begin
        if (accept) begin
            words.tx_word <= tx_data;
        end
    end

    // The engine may only take a word that the buffer actually offers.
    tx_taken_needs_word: assert property (
        @(posedge clk) disable iff (rst)
        words.tx_taken |-> words.tx_pending
    );

endmodule

`default_nettype wire

/* hdl/spi_word_if.sv */
// Word and frame event interface between the buffers and the shift engine.
`timescale 1ns/1ns
`default_nettype none

interface spi_word_if;

    spi_cfg_pkg::word_t tx_word;                 // Word waiting in the transmit buffer.
    logic               tx_pending;              // High while tx_word holds an unsent word.
    logic               tx_taken;                // One-cycle pulse, the engine has copied tx_word.

    spi_cfg_pkg::word_t rx_word;                 // Word assembled by the engine.
    logic               rx_done;                 // One-cycle pulse, rx_word is complete.

    // Transmit buffer. It offers a word and sees when the engine takes it.
    modport tx_side (
        output tx_word,
        output tx_pending,
        input  tx_taken
    );

    // Shift engine. It takes words from one side and hands results to the other.
    modport engine (
        input  tx_word,
        input  tx_pending,
        output tx_taken,
        output rx_word,
        output rx_done
    );

    // Receive buffer. It only listens for finished frames.
    modport rx_side (
        input  rx_word,
        input  rx_done
    );

endinterface

`default_nettype wire

/* hdl/spi_frame_pkg.sv */
// Shift engine state type and the edge counter union.
`default_nettype none

package spi_frame_pkg;

    // Idle waits for a buffered word, busy runs one frame.
    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } engine_state_t;

    // Every bit takes two sck half-periods, one per edge.
    localparam int half_periods_per_frame = 2 * spi_cfg_pkg::word_len;

    // One spare bit above the frame length lets the count run one past the last edge.
    localparam int edge_cnt_len = $clog2(half_periods_per_frame) + 1;
    localparam int bit_num_len  = edge_cnt_len - 1;

    typedef logic [bit_num_len-1:0] bit_num_t;

    localparam bit_num_t last_bit_num = bit_num_t'(spi_cfg_pkg::word_len - 1);

    // The engine counts half-periods in the raw view. It decodes the same word
    // as the bit being shifted and the sck phase within that bit.
    typedef union packed {
        logic [edge_cnt_len-1:0] raw;            // Plain half-period count.
        struct packed {
            bit_num_t bit_num;                   // Bit of the frame in flight.
            logic     phase;                     // 0 before the middle edge of a bit, 1 after.
        } part;
    } edge_count_u;

endpackage

`default_nettype wire

/* hdl/spi_cfg_pkg.sv */
// Word length, clock divider and SPI mode definitions.
`default_nettype none

package spi_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data word.

    localparam int word_len = 8;                 // Bits per SPI frame.

    typedef logic [word_len-1:0] word_t;         // One transmitted or received word.

    //////////////////////////////////////////////////////////////////////
    // Clock divider.

    // Encoded divider. A value p gives an sck half-period of 2^(p+1) clk cycles,
    // so the slowest setting (7) holds each sck level for 256 cycles.
    typedef logic [2:0] presc_t;

    localparam int presc_cnt_len = 8;            // Counts up to 255 for a 256 cycle half-period.

    typedef logic [presc_cnt_len-1:0] presc_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // SPI mode.

    // The classic mode number is {cpol, cpha}, which is why cpol is the upper field.
    typedef struct packed {
        logic cpol;                              // Idle level of sck.
        logic cpha;                              // 0 samples on the leading edge, 1 on the trailing.
    } spi_mode_t;

endpackage

`default_nettype wire
